// File: hdl/eth_tx_pkg.sv
/*
 * shared definitions for the 10G transmit path
 *  - lane widths and Ethernet framing bytes
 *  - XGMII control characters and gap limits
 *  - CRC-32 seed and polynomial, padding limits
 *  - frame buffer sizing and the framer state type
 */
package eth_tx_pkg;

    // 32-bit XGMII lane, one keep bit per byte
    localparam int data_w = 32;
    localparam int keep_w = data_w / 8;

    localparam int min_frame_length = 64;

    // padding limits, counted without the FCS
    localparam logic [15:0] min_fl_nocrc = 16'(min_frame_length - 4);
    localparam logic [15:0] min_fl_nocrc_ms = min_fl_nocrc & 16'hfffc;
    localparam logic [2:0] min_fl_nocrc_ls = 3'(min_fl_nocrc & 16'h0003);
    localparam logic [15:0] pad_stop_ptr =
        (min_fl_nocrc_ls > 0) ? min_fl_nocrc_ms : min_fl_nocrc_ms - 16'd4;
    localparam logic [keep_w-1:0] pad_last_keep = 4'hf >> ((4 - min_fl_nocrc_ls) % 4);

    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hd5;

    localparam logic [7:0] xgmii_idle = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hfb;
    localparam logic [7:0] xgmii_term = 8'hfd;
    localparam logic [7:0] xgmii_error = 8'hfe;

    // smallest gap in bytes
    localparam logic [7:0] ifg_min = 8'd12;

    localparam logic [31:0] crc_init = 32'hffffffff;
    localparam logic [31:0] crc_poly = 32'hedb88320;

    // buffer word is data, keep, last and user
    localparam int buf_words = 512;
    localparam int buf_addr_w = $clog2(buf_words);
    localparam int buf_word_w = data_w + keep_w + 2;
    localparam int max_frames = 16;
    localparam int frame_cnt_w = $clog2(max_frames + 1);

    typedef enum logic [2:0] {
        idle, preamble, payload, pad, fcs_1, fcs_2, fcs_3, ifg
    } tx_state_t;

endpackage

// File: hdl/axis_byte_if.sv
/*
 * byte stream link between the frame buffer and the framer
 * carries data with per-byte keep, frame end and error mark
 */
interface axis_byte_if;

    logic [eth_tx_pkg::data_w-1:0] tdata;
    logic [eth_tx_pkg::keep_w-1:0] tkeep;
    logic tvalid;
    logic tready;
    logic tlast;
    // set on the last word to abort the frame
    logic tuser;

    modport source (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

// File: hdl/eth_crc32.sv
/*
 * combinational CRC-32 step, reflected form
 * state after the first one, two, three and four bytes of a word
 */
module eth_crc32 (
    input  logic [eth_tx_pkg::data_w-1:0] data,
    input  logic [31:0]                   state_in,
    output logic [31:0]                   next_1,
    output logic [31:0]                   next_2,
    output logic [31:0]                   next_3,
    output logic [31:0]                   next_4
);

    // one byte, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) begin
                c = (c >> 1) ^ eth_tx_pkg::crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // each stage chains on the one before it
    assign next_1 = crc_byte(state_in, data[7:0]);
    assign next_2 = crc_byte(next_1, data[15:8]);
    assign next_3 = crc_byte(next_2, data[23:16]);
    assign next_4 = crc_byte(next_3, data[31:24]);

endmodule

// File: hdl/tx_frame_buffer.sv
/*
 * store-and-forward frame FIFO
 * counts complete frames and only releases whole ones,
 * so the output never stalls inside a frame
 */
module tx_frame_buffer (
    input  logic                          clk,
    input  logic                          reset_crc,
    input  logic [eth_tx_pkg::data_w-1:0] s_axis_tdata,
    input  logic [eth_tx_pkg::keep_w-1:0] s_axis_tkeep,
    input  logic                          s_axis_tvalid,
    output logic                          s_axis_tready,
    input  logic                          s_axis_tlast,
    input  logic                          s_axis_tuser,
    axis_byte_if.source                   m
);

    logic [eth_tx_pkg::buf_word_w-1:0] mem [eth_tx_pkg::buf_words];
    logic [eth_tx_pkg::buf_word_w-1:0] rd_word;
    logic [eth_tx_pkg::buf_addr_w-1:0] wr_ptr;
    logic [eth_tx_pkg::buf_addr_w-1:0] rd_ptr;
    logic [eth_tx_pkg::buf_addr_w:0] used, used_next;
    logic [eth_tx_pkg::frame_cnt_w-1:0] frame_count, frame_count_next;
    logic wr_en;
    logic rd_en;
    logic rd_last;

    assign wr_en = s_axis_tvalid && s_axis_tready;
    assign rd_word = mem[rd_ptr];
    assign rd_last = rd_word[eth_tx_pkg::buf_word_w-2];
    // refill the output stage when empty or draining, complete frames only
    assign rd_en = (frame_count != 0) && (!m.tvalid || m.tready);

    always_comb begin
        used_next = used;
        if (wr_en && !rd_en) begin
            used_next = used + 1'b1;
        end else if (rd_en && !wr_en) begin
            used_next = used - 1'b1;
        end
        frame_count_next = frame_count;
        if ((wr_en && s_axis_tlast) && !(rd_en && rd_last)) begin
            frame_count_next = frame_count + 1'b1;
        end else if ((rd_en && rd_last) && !(wr_en && s_axis_tlast)) begin
            frame_count_next = frame_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used <= '0;
            frame_count <= '0;
            s_axis_tready <= 1'b0;
            m.tvalid <= 1'b0;
        end else begin
            used <= used_next;
            frame_count <= frame_count_next;
            // room for one more word and one more frame end
            s_axis_tready <= (used_next < eth_tx_pkg::buf_words) &&
                             (frame_count_next < eth_tx_pkg::max_frames);
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                m.tvalid <= 1'b1;
            end else if (m.tready) begin
                m.tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {s_axis_tuser, s_axis_tlast, s_axis_tkeep, s_axis_tdata};
        end
        if (rd_en) begin
            {m.tuser, m.tlast, m.tkeep, m.tdata} <= rd_word;
        end
    end

endmodule

// File: hdl/xgmii_tx_framer.sv
/*
 * XGMII transmit framer, 32-bit lane
 *  - start and preamble, payload, zero padding
 *  - FCS placed after the last valid byte, then terminate
 *  - tuser abort with error characters
 *  - inter-frame gap with deficit idle count
 */
module xgmii_tx_framer (
    input  logic                          clk,
    input  logic                          reset_crc,
    axis_byte_if.sink                     s,
    input  logic [7:0]                    ifg_delay,
    output logic [eth_tx_pkg::data_w-1:0] xgmii_txd,
    output logic [eth_tx_pkg::keep_w-1:0] xgmii_txc
);

    eth_tx_pkg::tx_state_t state_reg, state_next;

    logic crc_clear;
    logic crc_update;
    logic [31:0] crc_state;
    logic [31:0] crc_next_1;
    logic [31:0] crc_next_2;
    logic [31:0] crc_next_3;
    logic [31:0] crc_next_4;

    logic [eth_tx_pkg::data_w-1:0] tdata_masked;
    logic [eth_tx_pkg::data_w-1:0] s_tdata_reg, s_tdata_next;
    logic [eth_tx_pkg::keep_w-1:0] s_tkeep_reg, s_tkeep_next;

    logic [eth_tx_pkg::data_w-1:0] fcs_txd_0, fcs_txd_1;
    logic [eth_tx_pkg::keep_w-1:0] fcs_txc_1;
    logic [7:0] ifg_offset;
    logic extra_cycle;

    logic [15:0] frame_ptr_reg, frame_ptr_next;
    logic [7:0] ifg_target;
    logic [7:0] ifg_count_reg, ifg_count_next;
    logic [1:0] deficit_reg, deficit_next;
    logic tready_reg, tready_next;
    logic [eth_tx_pkg::data_w-1:0] txd_reg, txd_next;
    logic [eth_tx_pkg::keep_w-1:0] txc_reg, txc_next;

    assign s.tready = tready_reg;
    assign xgmii_txd = txd_reg;
    assign xgmii_txc = txc_reg;

    eth_crc32 crc_inst (
        .data(s_tdata_reg),
        .state_in(crc_state),
        .next_1(crc_next_1),
        .next_2(crc_next_2),
        .next_3(crc_next_3),
        .next_4(crc_next_4)
    );

    function automatic logic [2:0] keep2count(input logic [3:0] k);
        case (k)
            4'b0001: return 3'd1;
            4'b0011: return 3'd2;
            4'b0111: return 3'd3;
            4'b1111: return 3'd4;
            default: return 3'd0;
        endcase
    endfunction

    // unused bytes read as zero, so they double as padding
    always_comb begin
        for (int j = 0; j < eth_tx_pkg::keep_w; j++) begin
            tdata_masked[j*8 +: 8] = s.tkeep[j] ? s.tdata[j*8 +: 8] : 8'd0;
        end
    end

    assign ifg_target = (ifg_delay > eth_tx_pkg::ifg_min) ? ifg_delay : eth_tx_pkg::ifg_min;

    // FCS words by final keep; offset is the gap already spent
    always_comb begin
        fcs_txd_0 = s_tdata_reg;
        fcs_txd_1 = ~crc_next_4;
        fcs_txc_1 = 4'b0000;
        ifg_offset = 8'd4;
        extra_cycle = 1'b1;
        case (s_tkeep_reg)
            4'b0001: begin
                fcs_txd_0 = {~crc_next_1[23:0], s_tdata_reg[7:0]};
                fcs_txd_1 = {{2{eth_tx_pkg::xgmii_idle}}, eth_tx_pkg::xgmii_term,
                             ~crc_next_1[31:24]};
                fcs_txc_1 = 4'b1110;
                ifg_offset = 8'd3;
                extra_cycle = 1'b0;
            end
            4'b0011: begin
                fcs_txd_0 = {~crc_next_2[15:0], s_tdata_reg[15:0]};
                fcs_txd_1 = {eth_tx_pkg::xgmii_idle, eth_tx_pkg::xgmii_term, ~crc_next_2[31:16]};
                fcs_txc_1 = 4'b1100;
                ifg_offset = 8'd2;
                extra_cycle = 1'b0;
            end
            4'b0111: begin
                fcs_txd_0 = {~crc_next_3[7:0], s_tdata_reg[23:0]};
                fcs_txd_1 = {eth_tx_pkg::xgmii_term, ~crc_next_3[31:8]};
                fcs_txc_1 = 4'b1000;
                ifg_offset = 8'd1;
                extra_cycle = 1'b0;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_next = eth_tx_pkg::idle;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        frame_ptr_next = frame_ptr_reg;
        ifg_count_next = ifg_count_reg;
        deficit_next = deficit_reg;
        tready_next = 1'b0;
        s_tdata_next = s_tdata_reg;
        s_tkeep_next = s_tkeep_reg;
        txd_next = {4{eth_tx_pkg::xgmii_idle}};
        txc_next = 4'b1111;

        case (state_reg)
            eth_tx_pkg::idle: begin
                frame_ptr_next = 16'd4;
                crc_clear = 1'b1;
                s_tdata_next = tdata_masked;
                s_tkeep_next = s.tkeep;
                if (s.tvalid) begin
                    txd_next = {{3{eth_tx_pkg::eth_pre}}, eth_tx_pkg::xgmii_start};
                    txc_next = 4'b0001;
                    tready_next = 1'b1;
                    state_next = eth_tx_pkg::preamble;
                end else begin
                    ifg_count_next = 8'd0;
                    deficit_next = 2'd0;
                end
            end
            eth_tx_pkg::preamble: begin
                // first word is taken here, held since idle
                s_tdata_next = tdata_masked;
                s_tkeep_next = s.tkeep;
                txd_next = {eth_tx_pkg::eth_sfd, {3{eth_tx_pkg::eth_pre}}};
                txc_next = 4'b0000;
                tready_next = 1'b1;
                state_next = eth_tx_pkg::payload;
            end
            eth_tx_pkg::payload: begin
                crc_update = 1'b1;
                tready_next = 1'b1;
                frame_ptr_next = frame_ptr_reg + 16'd4;
                txd_next = s_tdata_reg;
                txc_next = 4'b0000;
                s_tdata_next = tdata_masked;
                s_tkeep_next = s.tkeep;
                state_next = eth_tx_pkg::payload;
                if (s.tvalid && s.tlast) begin
                    tready_next = 1'b0;
                    frame_ptr_next = frame_ptr_reg + 16'(keep2count(s.tkeep));
                    state_next = eth_tx_pkg::fcs_1;
                    if (s.tuser) begin
                        // abort, no FCS and a fixed gap
                        txd_next = {eth_tx_pkg::xgmii_term, {3{eth_tx_pkg::xgmii_error}}};
                        txc_next = 4'b1111;
                        frame_ptr_next = 16'd0;
                        ifg_count_next = 8'd10;
                        state_next = eth_tx_pkg::ifg;
                    end else if (frame_ptr_reg < eth_tx_pkg::min_fl_nocrc_ms ||
                                 (frame_ptr_reg == eth_tx_pkg::min_fl_nocrc_ms &&
                                  keep2count(s.tkeep) < eth_tx_pkg::min_fl_nocrc_ls)) begin
                        s_tkeep_next = 4'hf;
                        frame_ptr_next = frame_ptr_reg + 16'd4;
                        if (frame_ptr_reg < eth_tx_pkg::pad_stop_ptr) begin
                            state_next = eth_tx_pkg::pad;
                        end else begin
                            s_tkeep_next = eth_tx_pkg::pad_last_keep;
                        end
                    end
                end
            end
            eth_tx_pkg::pad: begin
                txd_next = s_tdata_reg;
                txc_next = 4'b0000;
                s_tdata_next = '0;
                s_tkeep_next = 4'hf;
                crc_update = 1'b1;
                frame_ptr_next = frame_ptr_reg + 16'd4;
                if (frame_ptr_reg < eth_tx_pkg::pad_stop_ptr) begin
                    state_next = eth_tx_pkg::pad;
                end else begin
                    s_tkeep_next = eth_tx_pkg::pad_last_keep;
                    state_next = eth_tx_pkg::fcs_1;
                end
            end
            eth_tx_pkg::fcs_1: begin
                txd_next = fcs_txd_0;
                txc_next = 4'b0000;
                frame_ptr_next = 16'd0;
                ifg_count_next = ifg_target - ifg_offset + 8'(deficit_reg);
                state_next = eth_tx_pkg::fcs_2;
            end
            eth_tx_pkg::fcs_2: begin
                txd_next = fcs_txd_1;
                txc_next = fcs_txc_1;
                // gap still runs at least 9 bytes here
                state_next = extra_cycle ? eth_tx_pkg::fcs_3 : eth_tx_pkg::ifg;
            end
            eth_tx_pkg::fcs_3: begin
                txd_next = {{3{eth_tx_pkg::xgmii_idle}}, eth_tx_pkg::xgmii_term};
                crc_clear = 1'b1;
                state_next = eth_tx_pkg::ifg;
            end
            eth_tx_pkg::ifg: begin
                crc_clear = 1'b1;
                ifg_count_next = (ifg_count_reg > 8'd4) ? ifg_count_reg - 8'd4 : 8'd0;
                state_next = eth_tx_pkg::ifg;
                // leftover of 3 bytes or less carries into the next gap
                if (ifg_count_next <= 8'd3) begin
                    deficit_next = ifg_count_next[1:0];
                    ifg_count_next = 8'd0;
                    state_next = eth_tx_pkg::idle;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg <= eth_tx_pkg::idle;
            frame_ptr_reg <= 16'd0;
            ifg_count_reg <= 8'd0;
            deficit_reg <= 2'd0;
            tready_reg <= 1'b0;
            txd_reg <= {4{eth_tx_pkg::xgmii_idle}};
            txc_reg <= 4'b1111;
            crc_state <= eth_tx_pkg::crc_init;
        end else begin
            state_reg <= state_next;
            frame_ptr_reg <= frame_ptr_next;
            ifg_count_reg <= ifg_count_next;
            deficit_reg <= deficit_next;
            tready_reg <= tready_next;
            txd_reg <= txd_next;
            txc_reg <= txc_next;
            if (crc_clear) begin
                crc_state <= eth_tx_pkg::crc_init;
            end else if (crc_update) begin
                crc_state <= crc_next_4;
            end
        end
    end

    always_ff @(posedge clk) begin
        s_tdata_reg <= s_tdata_next;
        s_tkeep_reg <= s_tkeep_next;
    end

endmodule

// File: hdl/eth_tx_top.sv
/*
 * 10G Ethernet MAC transmit top
 * frame buffer feeding the XGMII framer
 */
module eth_tx_top (
    input  logic                          clk,
    input  logic                          reset_crc,
    input  logic [eth_tx_pkg::data_w-1:0] s_axis_tdata,
    input  logic [eth_tx_pkg::keep_w-1:0] s_axis_tkeep,
    input  logic                          s_axis_tvalid,
    output logic                          s_axis_tready,
    input  logic                          s_axis_tlast,
    input  logic                          s_axis_tuser,
    input  logic [7:0]                    ifg_delay,
    output logic [eth_tx_pkg::data_w-1:0] xgmii_txd,
    output logic [eth_tx_pkg::keep_w-1:0] xgmii_txc
);

    // whole frames only past this point
    axis_byte_if frame_bus ();

    tx_frame_buffer buffer_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_axis_tdata(s_axis_tdata),
        .s_axis_tkeep(s_axis_tkeep),
        .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tready(s_axis_tready),
        .s_axis_tlast(s_axis_tlast),
        .s_axis_tuser(s_axis_tuser),
        .m(frame_bus.source)
    );

    xgmii_tx_framer framer_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .s(frame_bus.sink),
        .ifg_delay(ifg_delay),
        .xgmii_txd(xgmii_txd),
        .xgmii_txc(xgmii_txc)
    );

endmodule

// File: verif/tb_eth_tx_assertions.sv
/*
 * concurrent checks bound into the XGMII framer
 * txc after reset, start lane, state order into preamble
 */
module tb_eth_tx_assertions (
    input logic                          clk,
    input logic                          reset_crc,
    input eth_tx_pkg::tx_state_t         state,
    input logic [eth_tx_pkg::data_w-1:0] xgmii_txd,
    input logic [eth_tx_pkg::keep_w-1:0] xgmii_txc
);

    int fail_count = 0;
    logic start_upper;

    // start character in lanes 1 to 3
    always_comb begin
        start_upper = 1'b0;
        for (int i = 1; i < eth_tx_pkg::keep_w; i++) begin
            if (xgmii_txc[i] && xgmii_txd[i*8 +: 8] == eth_tx_pkg::xgmii_start) begin
                start_upper = 1'b1;
            end
        end
    end

    txc_after_reset: assert property (@(posedge clk) reset_crc |=> (xgmii_txc == 4'hf))
    else begin
        fail_count++;
        $error("txc is not all ones after reset");
    end

    start_lane_zero: assert property (@(posedge clk) disable iff (reset_crc) !start_upper)
    else begin
        fail_count++;
        $error("start character outside lane 0");
    end

    preamble_from_idle: assert property (@(posedge clk) disable iff (reset_crc)
        (state == eth_tx_pkg::preamble) |-> ($past(state) == eth_tx_pkg::idle))
    else begin
        fail_count++;
        $error("preamble entered from a state other than idle");
    end

endmodule

// File: verif/tb_eth_tx.sv
/*
 * directed testbench for the 10G transmit path
 *  - clock, reset and LFSR payload source
 *  - reference CRC-32 and XGMII byte monitor
 *  - tests for idle, padding and FCS, abort, gaps and back-pressure
 */
module tb_eth_tx;

    // normal (non-reflected) form of the Ethernet polynomial
    localparam logic [31:0] poly_normal = 32'h04c11db7;
    localparam int wait_limit = 5000;

    logic clk;
    logic reset_crc;
    logic [eth_tx_pkg::data_w-1:0] s_axis_tdata;
    logic [eth_tx_pkg::keep_w-1:0] s_axis_tkeep;
    logic s_axis_tvalid;
    logic s_axis_tready;
    logic s_axis_tlast;
    logic s_axis_tuser;
    logic [7:0] ifg_delay;
    logic [eth_tx_pkg::data_w-1:0] xgmii_txd;
    logic [eth_tx_pkg::keep_w-1:0] xgmii_txc;

    logic [15:0] lfsr_state = 16'd21;
    logic [7:0] payload[$];
    logic [7:0] body[$];
    logic [7:0] exp_bytes[$];
    int exp_len[$];
    bit exp_err[$];
    logic [7:0] rx_bytes[$];
    int rx_len[$];
    bit rx_err[$];
    int rx_gap[$];
    bit stalled;

    eth_tx_top eth_tx_top_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_axis_tdata(s_axis_tdata),
        .s_axis_tkeep(s_axis_tkeep),
        .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tready(s_axis_tready),
        .s_axis_tlast(s_axis_tlast),
        .s_axis_tuser(s_axis_tuser),
        .ifg_delay(ifg_delay),
        .xgmii_txd(xgmii_txd),
        .xgmii_txc(xgmii_txc)
    );

    bind xgmii_tx_framer tb_eth_tx_assertions framer_checks (
        .clk(clk),
        .reset_crc(reset_crc),
        .state(state_reg),
        .xgmii_txd(xgmii_txd),
        .xgmii_txc(xgmii_txc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, want));
        end
    endtask

    task automatic check_ctrl(input string name, input logic [eth_tx_pkg::keep_w-1:0] got,
                              input logic [eth_tx_pkg::keep_w-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_lfsr_bit());
        end
        return v;
    endfunction

    // msb-first register fed lsb first, reflected and inverted at the end
    function automatic logic [31:0] crc32_ref();
        logic [31:0] r;
        logic [31:0] out;
        logic fb;
        r = eth_tx_pkg::crc_init;
        foreach (body[i]) begin
            for (int k = 0; k < 8; k++) begin
                fb = r[31] ^ body[i][k];
                r = r << 1;
                if (fb) begin
                    r = r ^ poly_normal;
                end
            end
        end
        for (int k = 0; k < 32; k++) begin
            out[k] = r[31-k];
        end
        return ~out;
    endfunction

    task automatic make_payload(input int len);
        payload.delete();
        repeat (len) begin
            payload.push_back(8'(rand_bits(8)));
        end
    endtask

    // preamble, body padded to 60, FCS lsb first
    task automatic expect_frame(input bit abort);
        logic [31:0] fcs;
        body = payload;
        while (body.size() < eth_tx_pkg::min_frame_length - 4) begin
            body.push_back(8'h00);
        end
        fcs = crc32_ref();
        exp_err.push_back(abort);
        exp_len.push_back(7 + body.size() + 4);
        if (!abort) begin
            repeat (6) exp_bytes.push_back(eth_tx_pkg::eth_pre);
            exp_bytes.push_back(eth_tx_pkg::eth_sfd);
            foreach (body[i]) begin
                exp_bytes.push_back(body[i]);
            end
            for (int i = 0; i < 4; i++) begin
                exp_bytes.push_back(fcs[i*8 +: 8]);
            end
        end
    endtask

    task automatic hold_until_accepted();
        int waited;
        waited = 0;
        while (!s_axis_tready) begin
            stalled = 1'b1;
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("input word was never accepted by the buffer");
            end
        end
        @(negedge clk);
    endtask

    task automatic send_frame(input bit abort);
        int words;
        int n;
        words = (payload.size() + 3) / 4;
        for (int w = 0; w < words; w++) begin
            n = (payload.size() - w * 4 > 4) ? 4 : payload.size() - w * 4;
            for (int j = 0; j < 4; j++) begin
                s_axis_tkeep[j] = (j < n);
                // junk beyond keep, must never reach the line
                s_axis_tdata[j*8 +: 8] = 8'hee;
                if (j < n) begin
                    s_axis_tdata[j*8 +: 8] = payload[w*4+j];
                end
            end
            s_axis_tvalid = 1'b1;
            s_axis_tlast = (w == words - 1);
            s_axis_tuser = abort && (w == words - 1);
            hold_until_accepted();
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
        s_axis_tuser = 1'b0;
    endtask

    task automatic wait_for_frames(input int n);
        int waited;
        waited = 0;
        while (rx_len.size() < n) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("timed out waiting for frames on XGMII");
            end
        end
    endtask

    task automatic compare_frames(input int n);
        int len;
        int want_len;
        bit err;
        bit abort;
        for (int f = 0; f < n; f++) begin
            len = rx_len.pop_front();
            err = rx_err.pop_front();
            want_len = exp_len.pop_front();
            abort = exp_err.pop_front();
            check_count("frame error mark", int'(err), int'(abort));
            if (abort) begin
                repeat (len) void'(rx_bytes.pop_front());
            end else begin
                check_count("frame length", len, want_len);
                for (int i = 0; i < len; i++) begin
                    check_byte($sformatf("xgmii_txd byte %0d", i), rx_bytes.pop_front(),
                               exp_bytes.pop_front());
                end
            end
        end
    endtask

    // bytes between start and terminate, idles between frames
    initial begin : xgmii_monitor
        logic [7:0] b;
        bit in_frame;
        bit seen_term;
        bit frame_err;
        int frame_bytes;
        int gap_run;
        forever begin
            @(negedge clk);
            if (!reset_crc) begin
                for (int i = 0; i < eth_tx_pkg::keep_w; i++) begin
                    b = xgmii_txd[i*8 +: 8];
                    if (xgmii_txc[i] && b == eth_tx_pkg::xgmii_start) begin
                        check_ctrl("xgmii_txc", xgmii_txc, 4'b0001);
                        if (seen_term) begin
                            rx_gap.push_back(gap_run);
                        end
                        in_frame = 1'b1;
                        frame_err = 1'b0;
                        frame_bytes = 0;
                    end else if (in_frame && !xgmii_txc[i]) begin
                        rx_bytes.push_back(b);
                        frame_bytes++;
                    end else if (in_frame && b == eth_tx_pkg::xgmii_term) begin
                        rx_len.push_back(frame_bytes);
                        rx_err.push_back(frame_err);
                        in_frame = 1'b0;
                        seen_term = 1'b1;
                        // terminate counts as the first gap byte
                        gap_run = 1;
                    end else if (in_frame && b == eth_tx_pkg::xgmii_error) begin
                        frame_err = 1'b1;
                    end else if (xgmii_txc[i] && b == eth_tx_pkg::xgmii_idle) begin
                        gap_run++;
                    end
                end
            end
        end
    end

    task automatic idle_after_reset();
        repeat (16) begin
            @(negedge clk);
            check_ctrl("xgmii_txc", xgmii_txc, 4'hf);
            for (int j = 0; j < 4; j++) begin
                check_byte("xgmii_txd idle lane", xgmii_txd[j*8 +: 8], eth_tx_pkg::xgmii_idle);
            end
        end
    endtask

    // every final keep, with and without padding
    task automatic frame_length_sweep();
        int lengths[14] = '{20, 21, 22, 23, 57, 58, 59, 60, 61, 62, 63, 64, 99, 100};
        foreach (lengths[i]) begin
            make_payload(lengths[i]);
            expect_frame(1'b0);
            send_frame(1'b0);
            wait_for_frames(1);
            compare_frames(1);
        end
    endtask

    task automatic abort_then_recover();
        make_payload(40);
        expect_frame(1'b1);
        send_frame(1'b1);
        make_payload(44);
        expect_frame(1'b0);
        send_frame(1'b0);
        wait_for_frames(2);
        compare_frames(2);
    endtask

    task automatic gap_control(input logic [7:0] delay);
        int target;
        int sum;
        int g;
        target = (delay > eth_tx_pkg::ifg_min) ? int'(delay) : int'(eth_tx_pkg::ifg_min);
        ifg_delay = delay;
        rx_gap.delete();
        for (int f = 0; f < 8; f++) begin
            make_payload(64 + rand_bits(4));
            expect_frame(1'b0);
            send_frame(1'b0);
        end
        wait_for_frames(8);
        compare_frames(8);
        check_count("gap count", rx_gap.size(), 8);
        // first gap follows the previous test, not this burst
        void'(rx_gap.pop_front());
        sum = 0;
        for (int i = 0; i < 7; i++) begin
            g = rx_gap.pop_front();
            sum += g;
            if (g < target - 3 || g > target + 3) begin
                abort_run($sformatf("gap of %0d bytes is more than 3 from %0d", g, target));
            end
        end
        if (sum < 7 * (target - 1)) begin
            abort_run($sformatf("average gap over 7 gaps is below %0d bytes", target - 1));
        end
    endtask

    // short frames fill the buffer faster than the line drains it
    task automatic backpressure_burst();
        stalled = 1'b0;
        for (int f = 0; f < 30; f++) begin
            make_payload(20 + rand_bits(3));
            expect_frame(1'b0);
            send_frame(1'b0);
        end
        if (!stalled) begin
            abort_run("s_axis_tready never dropped during the burst");
        end
        wait_for_frames(30);
        compare_frames(30);
    endtask

    initial begin
        reset_crc = 1'b1;
        s_axis_tdata = '0;
        s_axis_tkeep = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
        s_axis_tuser = 1'b0;
        ifg_delay = 8'd12;
        stalled = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_crc = 1'b0;

        idle_after_reset();
        frame_length_sweep();
        abort_then_recover();
        gap_control(8'd12);
        gap_control(8'd20);
        backpressure_burst();

        if (eth_tx_top_inst.framer_inst.framer_checks.fail_count != 0) begin
            abort_run("a framer assertion failed during the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: sim.f
hdl/eth_tx_pkg.sv
hdl/axis_byte_if.sv
hdl/eth_crc32.sv
hdl/tx_frame_buffer.sv
hdl/xgmii_tx_framer.sv
hdl/eth_tx_top.sv
verif/tb_eth_tx_assertions.sv
verif/tb_eth_tx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_eth_tx
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
